// File: hw/rv_decode_pkg.sv
package rv_decode_pkg;

  localparam int XLEN       = 32;
  localparam int REG_ADDR_W = 5;
  localparam int CSR_ADDR_W = 12;

  localparam logic [REG_ADDR_W-1:0] LINK_REG_A = 5'd1; // ra
  localparam logic [REG_ADDR_W-1:0] LINK_REG_B = 5'd5; // t0

  localparam logic [XLEN-1:0] NOP_INSTR = 32'h0000_0013; // addi x0,x0,0.

  localparam logic [CSR_ADDR_W-1:0] CSR_ECALL  = 12'h000;
  localparam logic [CSR_ADDR_W-1:0] CSR_EBREAK = 12'h001;
  localparam logic [CSR_ADDR_W-1:0] CSR_MRET   = 12'h302;
  localparam logic [CSR_ADDR_W-1:0] CSR_WFI    = 12'h105;

  localparam logic [6:0] FUNCT7_BASE   = 7'h00;
  localparam logic [6:0] FUNCT7_ALT    = 7'h20;
  localparam logic [6:0] FUNCT7_MULDIV = 7'h01;

  typedef enum logic [6:0] {
    opc_lui    = 7'b0110111,
    opc_auipc  = 7'b0010111,
    opc_jal    = 7'b1101111,
    opc_jalr   = 7'b1100111,
    opc_branch = 7'b1100011,
    opc_load   = 7'b0000011,
    opc_store  = 7'b0100011,
    opc_op_imm = 7'b0010011,
    opc_op     = 7'b0110011,
    opc_fence  = 7'b0001111,
    opc_system = 7'b1110011
  } opcode_e;

  typedef enum logic [2:0] {
    fmt_none, fmt_i, fmt_s, fmt_b, fmt_u, fmt_j, fmt_c
  } imm_fmt_e;

  typedef enum logic [3:0] {
    alu_none, alu_add, alu_sub, alu_sll, alu_slt, alu_sltu,
    alu_xor, alu_srl, alu_sra, alu_or, alu_and
  } alu_op_e;

  typedef enum logic [3:0] {
    md_none, md_mul, md_mulh, md_mulhsu, md_mulhu,
    md_div, md_divu, md_rem, md_remu
  } muldiv_op_e;

  typedef enum logic [3:0] {
    lsu_none, lsu_lb, lsu_lh, lsu_lw, lsu_lbu, lsu_lhu,
    lsu_sb, lsu_sh, lsu_sw
  } lsu_op_e;

  typedef enum logic [2:0] {
    bcu_none, bcu_beq, bcu_bne, bcu_blt, bcu_bge, bcu_bltu, bcu_bgeu
  } bcu_op_e;

  typedef enum logic [2:0] {
    csr_none, csr_rw, csr_rs, csr_rc, csr_rwi, csr_rsi, csr_rci
  } csr_op_e;

  typedef struct packed {
    logic [XLEN-1:0] imm;
    logic            wren;
    logic            rden1;
    logic            rden2;
    logic            cwren;
    logic            crden;
    logic            lui;
    logic            auipc;
    logic            jal;
    logic            jalr;
    logic            branch;
    logic            load;
    logic            store;
    logic            nop;
    logic            csreg;
    logic            mult;
    logic            division;
    logic            fence;
    logic            ecall;
    logic            ebreak;
    logic            mret;
    logic            wfi;
    logic            return_push;
    logic            return_pop;
    logic            jump_uncond;
    logic            jump_rest;
    logic            legal;
    alu_op_e         alu_op;
    muldiv_op_e      muldiv_op;
    bcu_op_e         bcu_op;
    lsu_op_e         lsu_op;
    csr_op_e         csr_op;
  } decode_out_t;

endpackage

// File: hw/imm_gen.sv
`timescale 1ns/1ns

module imm_gen (
  input  logic [rv_decode_pkg::XLEN-1:0] instr,
  input  rv_decode_pkg::imm_fmt_e        imm_fmt,
  output logic [rv_decode_pkg::XLEN-1:0] imm
);
  import rv_decode_pkg::*;

  logic [XLEN-1:0] imm_i;
  logic [XLEN-1:0] imm_s;
  logic [XLEN-1:0] imm_b;
  logic [XLEN-1:0] imm_u;
  logic [XLEN-1:0] imm_j;
  logic [XLEN-1:0] imm_c;

  assign imm_i = {{20{instr[31]}}, instr[31:20]};
  assign imm_s = {{20{instr[31]}}, instr[31:25], instr[11:7]};
  assign imm_b = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
  assign imm_u = {instr[31:12], 12'h000};
  assign imm_j = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};
  assign imm_c = {27'h0, instr[19:15]}; // uimm sits in the rs1 field.

  always_comb begin
    case (imm_fmt)
      fmt_i:   imm = imm_i;
      fmt_s:   imm = imm_s;
      fmt_b:   imm = imm_b;
      fmt_u:   imm = imm_u;
      fmt_j:   imm = imm_j;
      fmt_c:   imm = imm_c;
      default: imm = '0;
    endcase
  end

endmodule

// File: hw/alu_decode.sv
`timescale 1ns/1ns

module alu_decode (
  input  logic [2:0]                  funct3,
  input  logic [6:0]                  funct7,
  input  logic                        is_op,
  input  logic                        is_op_imm,
  input  logic                        is_branch,
  input  logic                        is_load,
  input  logic                        is_store,
  output rv_decode_pkg::alu_op_e      alu_op,
  output rv_decode_pkg::muldiv_op_e   muldiv_op,
  output rv_decode_pkg::bcu_op_e      bcu_op,
  output rv_decode_pkg::lsu_op_e      lsu_op,
  output logic                        fn_legal
);
  import rv_decode_pkg::*;

  // Shared by OP with base funct7 and OP-IMM.
  function automatic alu_op_e base_op(input logic [2:0] f3);
    case (f3)
      3'd0:    return alu_add;
      3'd1:    return alu_sll;
      3'd2:    return alu_slt;
      3'd3:    return alu_sltu;
      3'd4:    return alu_xor;
      3'd5:    return alu_srl;
      3'd6:    return alu_or;
      default: return alu_and;
    endcase
  endfunction

  always_comb begin
    alu_op    = alu_none;
    muldiv_op = md_none;
    bcu_op    = bcu_none;
    lsu_op    = lsu_none;
    fn_legal  = 1'b1;
    if (is_op) begin
      case (funct7)
        FUNCT7_BASE: alu_op = base_op(funct3);
        FUNCT7_ALT: begin
          if (funct3 == 3'd0) alu_op = alu_sub;
          else if (funct3 == 3'd5) alu_op = alu_sra;
          else fn_legal = 1'b0;
        end
        FUNCT7_MULDIV: muldiv_op = muldiv_op_e'({1'b0, funct3} + 4'd1); // Same order as funct3.
        7'h04, 7'h05, 7'h10, 7'h14, 7'h24, 7'h30, 7'h34: fn_legal = 1'b0; // Old Zb* slots.
        default: ;
      endcase
    end
    if (is_op_imm) begin
      if (funct3 == 3'd1 && funct7 != FUNCT7_BASE) fn_legal = 1'b0;
      else if (funct3 == 3'd5 && funct7 == FUNCT7_ALT) alu_op = alu_sra;
      else if (funct3 == 3'd5 && funct7 != FUNCT7_BASE) fn_legal = 1'b0;
      else alu_op = base_op(funct3);
    end
    if (is_branch) begin
      case (funct3)
        3'd0:    bcu_op = bcu_beq;
        3'd1:    bcu_op = bcu_bne;
        3'd4:    bcu_op = bcu_blt;
        3'd5:    bcu_op = bcu_bge;
        3'd6:    bcu_op = bcu_bltu;
        3'd7:    bcu_op = bcu_bgeu;
        default: fn_legal = 1'b0;
      endcase
    end
    if (is_load) begin
      case (funct3)
        3'd0:    lsu_op = lsu_lb;
        3'd1:    lsu_op = lsu_lh;
        3'd2:    lsu_op = lsu_lw;
        3'd4:    lsu_op = lsu_lbu;
        3'd5:    lsu_op = lsu_lhu;
        default: fn_legal = 1'b0;
      endcase
    end
    if (is_store) begin
      case (funct3)
        3'd0:    lsu_op = lsu_sb;
        3'd1:    lsu_op = lsu_sh;
        3'd2:    lsu_op = lsu_sw;
        default: fn_legal = 1'b0;
      endcase
    end
  end

endmodule

// File: hw/csr_decode.sv
`timescale 1ns/1ns

module csr_decode (
  input  logic                                is_system,
  input  logic [2:0]                          funct3,
  input  logic [rv_decode_pkg::CSR_ADDR_W-1:0] csr_addr,
  input  logic                                rd_nonzero,
  input  logic [rv_decode_pkg::REG_ADDR_W-1:0] rs1_field,
  output logic                                cwren,
  output logic                                crden,
  output logic                                csr_wren,
  output rv_decode_pkg::csr_op_e              csr_op,
  output logic                                ecall,
  output logic                                ebreak,
  output logic                                mret,
  output logic                                wfi,
  output logic                                sys_legal
);
  import rv_decode_pkg::*;

  logic src_nonzero;

  assign src_nonzero = |rs1_field; // rs1 or uimm, same bits.

  always_comb begin
    csr_op    = csr_none;
    cwren     = 1'b0;
    crden     = 1'b0;
    ecall     = 1'b0;
    ebreak    = 1'b0;
    mret      = 1'b0;
    wfi       = 1'b0;
    sys_legal = 1'b1;
    if (is_system) begin
      case (funct3)
        3'd0: begin
          case (csr_addr)
            CSR_ECALL:  ecall = 1'b1;
            CSR_EBREAK: ebreak = 1'b1;
            CSR_MRET:   mret = 1'b1;
            CSR_WFI:    wfi = 1'b1;
            default:    sys_legal = 1'b0;
          endcase
        end
        3'd1:    csr_op = csr_rw;
        3'd2:    csr_op = csr_rs;
        3'd3:    csr_op = csr_rc;
        3'd5:    csr_op = csr_rwi;
        3'd6:    csr_op = csr_rsi;
        3'd7:    csr_op = csr_rci;
        default: ; // funct3 4 is reserved but passes.
      endcase
      if (csr_op == csr_rw || csr_op == csr_rwi) begin
        cwren = 1'b1;
        crden = rd_nonzero; // No read side effects for rd = x0.
      end else if (csr_op != csr_none) begin
        cwren = src_nonzero;
        crden = 1'b1;
      end
    end
  end

  assign csr_wren = rd_nonzero && csr_op != csr_none;

endmodule

// File: hw/ras_hint.sv
`timescale 1ns/1ns

module ras_hint (
  input  logic                                is_jal,
  input  logic                                is_jalr,
  input  logic [rv_decode_pkg::REG_ADDR_W-1:0] rd,
  input  logic [rv_decode_pkg::REG_ADDR_W-1:0] rs1,
  output logic                                return_push,
  output logic                                return_pop,
  output logic                                jump_uncond,
  output logic                                jump_rest
);
  import rv_decode_pkg::*;

  logic link_rd;
  logic link_rs1;

  assign link_rd  = rd == LINK_REG_A || rd == LINK_REG_B;
  assign link_rs1 = rs1 == LINK_REG_A || rs1 == LINK_REG_B;

  always_comb begin
    return_push = 1'b0;
    return_pop  = 1'b0;
    jump_uncond = 1'b0;
    jump_rest   = 1'b0;
    if (is_jal) begin
      if (link_rd) return_push = 1'b1; // Call.
      else if (rd == '0) jump_uncond = 1'b1;
      else jump_rest = 1'b1;
    end
    if (is_jalr) begin
      if (link_rd || link_rs1) begin
        return_push = link_rd;
        return_pop  = link_rs1 && (!link_rd || rd != rs1); // Coroutine swap pops too.
      end else begin
        jump_rest = 1'b1;
      end
    end
  end

endmodule

// File: hw/decode_ctrl.sv
`timescale 1ns/1ns

module decode_ctrl (
  input  logic [rv_decode_pkg::XLEN-1:0] instr,
  input  logic [rv_decode_pkg::XLEN-1:0] imm,
  input  rv_decode_pkg::alu_op_e         alu_op,
  input  rv_decode_pkg::muldiv_op_e      muldiv_op,
  input  rv_decode_pkg::bcu_op_e         bcu_op,
  input  rv_decode_pkg::lsu_op_e         lsu_op,
  input  logic                           fn_legal,
  input  rv_decode_pkg::csr_op_e         csr_op,
  input  logic                           cwren,
  input  logic                           crden,
  input  logic                           csr_wren,
  input  logic                           ecall,
  input  logic                           ebreak,
  input  logic                           mret,
  input  logic                           wfi,
  input  logic                           sys_legal,
  input  logic                           return_push,
  input  logic                           return_pop,
  input  logic                           jump_uncond,
  input  logic                           jump_rest,
  output rv_decode_pkg::imm_fmt_e        imm_fmt,
  output logic                           is_op,
  output logic                           is_op_imm,
  output logic                           is_branch,
  output logic                           is_load,
  output logic                           is_store,
  output logic                           is_system,
  output logic                           is_jal,
  output logic                           is_jalr,
  output rv_decode_pkg::decode_out_t     decoded
);
  import rv_decode_pkg::*;

  opcode_e     opcode;
  logic        rd_nonzero;
  logic        known;
  logic        is_nop;
  decode_out_t ctrl;

  assign opcode     = opcode_e'(instr[6:0]);
  assign rd_nonzero = |instr[11:7];
  assign is_nop     = instr == NOP_INSTR;

  // Opcode table.
  always_comb begin
    ctrl      = '0;
    imm_fmt   = fmt_none;
    is_op     = 1'b0;
    is_op_imm = 1'b0;
    is_branch = 1'b0;
    is_load   = 1'b0;
    is_store  = 1'b0;
    is_system = 1'b0;
    is_jal    = 1'b0;
    is_jalr   = 1'b0;
    known     = 1'b1;
    case (opcode)
      opc_lui: begin
        imm_fmt = fmt_u;
        ctrl.lui = 1'b1;
      end
      opc_auipc: begin
        imm_fmt = fmt_u;
        ctrl.auipc = 1'b1;
      end
      opc_jal: begin
        imm_fmt = fmt_j;
        is_jal = 1'b1;
      end
      opc_jalr: begin
        imm_fmt = fmt_i;
        is_jalr = 1'b1;
      end
      opc_branch: begin
        imm_fmt = fmt_b;
        is_branch = 1'b1;
      end
      opc_load: begin
        imm_fmt = fmt_i;
        is_load = 1'b1;
      end
      opc_store: begin
        imm_fmt = fmt_s;
        is_store = 1'b1;
      end
      opc_op_imm: begin
        imm_fmt = fmt_i;
        is_op_imm = 1'b1;
      end
      opc_op:     is_op = 1'b1;
      opc_fence:  ctrl.fence = instr[14:13] == 2'b00; // fence or fence.i.
      opc_system: begin
        imm_fmt = fmt_c;
        is_system = 1'b1;
      end
      default:    known = 1'b0;
    endcase
    ctrl.jal    = is_jal;
    ctrl.jalr   = is_jalr;
    ctrl.branch = is_branch;
    ctrl.load   = is_load;
    ctrl.store  = is_store;
    ctrl.wren   = rd_nonzero && (ctrl.lui || ctrl.auipc || is_jal || is_jalr
                                 || is_load || is_op_imm || is_op);
    ctrl.rden1  = is_jalr || is_branch || is_load || is_store || is_op_imm || is_op;
    ctrl.rden2  = is_branch || is_store || is_op;
  end

  // Merge sub-decoder results.
  always_comb begin
    decoded             = ctrl;
    decoded.imm         = imm;
    decoded.wren        = ctrl.wren || csr_wren;
    decoded.rden1       = ctrl.rden1 || csr_op inside {csr_rw, csr_rs, csr_rc};
    decoded.cwren       = cwren;
    decoded.crden       = crden;
    decoded.csreg       = csr_op != csr_none;
    decoded.mult        = muldiv_op inside {md_mul, md_mulh, md_mulhsu, md_mulhu};
    decoded.division    = muldiv_op inside {md_div, md_divu, md_rem, md_remu};
    decoded.ecall       = ecall;
    decoded.ebreak      = ebreak;
    decoded.mret        = mret;
    decoded.wfi         = wfi;
    decoded.return_push = return_push;
    decoded.return_pop  = return_pop;
    decoded.jump_uncond = jump_uncond;
    decoded.jump_rest   = jump_rest;
    decoded.legal       = known && fn_legal && sys_legal;
    decoded.nop         = is_nop;
    decoded.alu_op      = is_nop ? alu_none : alu_op;
    decoded.muldiv_op   = muldiv_op;
    decoded.bcu_op      = bcu_op;
    decoded.lsu_op      = lsu_op;
    decoded.csr_op      = csr_op;
  end

endmodule

// File: hw/decode_stage.sv
`timescale 1ns/1ns

module decode_stage (
  input  logic                           clock,
  input  logic                           rst,
  input  logic [rv_decode_pkg::XLEN-1:0] instr,
  input  logic                           in_valid,
  output rv_decode_pkg::decode_out_t     decode_out,
  output logic                           out_valid
);
  import rv_decode_pkg::*;

  decode_out_t     decoded;
  imm_fmt_e        imm_fmt;
  logic [XLEN-1:0] imm;
  alu_op_e         alu_op;
  muldiv_op_e      muldiv_op;
  bcu_op_e         bcu_op;
  lsu_op_e         lsu_op;
  csr_op_e         csr_op;
  logic            fn_legal;
  logic            sys_legal;
  logic            cwren;
  logic            crden;
  logic            csr_wren;
  logic            ecall;
  logic            ebreak;
  logic            mret;
  logic            wfi;
  logic            is_op;
  logic            is_op_imm;
  logic            is_branch;
  logic            is_load;
  logic            is_store;
  logic            is_system;
  logic            is_jal;
  logic            is_jalr;
  logic            return_push;
  logic            return_pop;
  logic            jump_uncond;
  logic            jump_rest;

  decode_ctrl u_ctrl (
    .instr(instr), .imm(imm), .alu_op(alu_op), .muldiv_op(muldiv_op),
    .bcu_op(bcu_op), .lsu_op(lsu_op), .fn_legal(fn_legal), .csr_op(csr_op),
    .cwren(cwren), .crden(crden), .csr_wren(csr_wren), .ecall(ecall),
    .ebreak(ebreak), .mret(mret), .wfi(wfi), .sys_legal(sys_legal),
    .return_push(return_push), .return_pop(return_pop),
    .jump_uncond(jump_uncond), .jump_rest(jump_rest), .imm_fmt(imm_fmt),
    .is_op(is_op), .is_op_imm(is_op_imm), .is_branch(is_branch),
    .is_load(is_load), .is_store(is_store), .is_system(is_system),
    .is_jal(is_jal), .is_jalr(is_jalr), .decoded(decoded)
  );

  imm_gen u_imm (.instr(instr), .imm_fmt(imm_fmt), .imm(imm));

  alu_decode u_alu (
    .funct3(instr[14:12]), .funct7(instr[31:25]), .is_op(is_op),
    .is_op_imm(is_op_imm), .is_branch(is_branch), .is_load(is_load),
    .is_store(is_store), .alu_op(alu_op), .muldiv_op(muldiv_op),
    .bcu_op(bcu_op), .lsu_op(lsu_op), .fn_legal(fn_legal)
  );

  csr_decode u_csr (
    .is_system(is_system), .funct3(instr[14:12]), .csr_addr(instr[31:20]),
    .rd_nonzero(|instr[11:7]), .rs1_field(instr[19:15]), .cwren(cwren),
    .crden(crden), .csr_wren(csr_wren), .csr_op(csr_op), .ecall(ecall),
    .ebreak(ebreak), .mret(mret), .wfi(wfi), .sys_legal(sys_legal)
  );

  ras_hint u_ras (
    .is_jal(is_jal), .is_jalr(is_jalr), .rd(instr[11:7]), .rs1(instr[19:15]),
    .return_push(return_push), .return_pop(return_pop),
    .jump_uncond(jump_uncond), .jump_rest(jump_rest)
  );

  always_ff @(posedge clock) begin
    if (rst) begin
      decode_out <= '0;
      out_valid  <= 1'b0;
    end else begin
      out_valid <= in_valid; // One-cycle strobe.
      if (in_valid) decode_out <= decoded;
    end
  end

endmodule

// File: bench/decode_stage_props.sv
`timescale 1ns/1ns

module decode_stage_props (
  input logic                           clock,
  input logic                           rst,
  input logic [rv_decode_pkg::XLEN-1:0] instr,
  input logic                           in_valid,
  input rv_decode_pkg::decode_out_t     decode_out,
  input logic                           out_valid
);
  import rv_decode_pkg::*;

  logic [REG_ADDR_W-1:0] rd_q; // rd of the word held in decode_out.

  always_ff @(posedge clock) begin
    if (!rst && in_valid) rd_q <= instr[11:7];
  end

  a_idle_after_reset: assert property (@(posedge clock) rst |=> !out_valid)
    else $error("out_valid high in the cycle after reset");

  a_valid_delay: assert property (@(posedge clock) !rst |=> out_valid == $past(in_valid))
    else $error("out_valid does not follow in_valid by one cycle");

  a_wren_rd: assert property (@(posedge clock) decode_out.wren |-> rd_q != '0)
    else $error("wren set for rd x0");

  a_csr_class: assert property (@(posedge clock)
    (decode_out.cwren || decode_out.crden) |-> decode_out.csreg)
    else $error("CSR enable without csreg");

  a_ras_jump: assert property (@(posedge clock)
    (decode_out.return_push || decode_out.return_pop) |-> (decode_out.jal || decode_out.jalr))
    else $error("RAS hint on a non-jump");

endmodule

bind decode_stage decode_stage_props u_props (
  .clock(clock), .rst(rst), .instr(instr), .in_valid(in_valid),
  .decode_out(decode_out), .out_valid(out_valid)
);

// File: bench/tb_decode_stage.sv
`timescale 1ns/1ns

module tb_decode_stage;
  import rv_decode_pkg::*;

  localparam int NUM_STROBES = 3000;
  localparam int MAX_CYCLES  = 2 * NUM_STROBES; // About 4000 cycles at 3/4 load.

  logic            clock;
  logic            rst;
  logic [XLEN-1:0] instr;
  logic            in_valid;
  decode_out_t     decode_out;
  logic            out_valid;

  logic [31:0]     lcg_state;
  logic [XLEN-1:0] last_instr;
  logic            last_valid;
  decode_out_t     expected;
  int              strobes;
  int              cycles;

  decode_stage DUT (
    .clock(clock), .rst(rst), .instr(instr), .in_valid(in_valid),
    .decode_out(decode_out), .out_valid(out_valid)
  );

  initial clock = 1'b0;
  always #10 clock = ~clock;

  initial cycles = 0;
  always @(posedge clock) begin
    cycles = cycles + 1;
    if (cycles >= MAX_CYCLES) begin
      $display("Timeout: %0d strobes not done after %0d cycles", NUM_STROBES, cycles);
      $display("Test failures found");
      $fatal(1, "Simulation stopped by the cycle limit.");
    end
  end

  function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  function automatic logic [XLEN-1:0] random_instr();
    logic [31:0] w;
    logic [31:0] r;
    logic [2:0]  f3;
    w = lcg_next();
    r = lcg_next();
    if (r[31]) return w; // Fully random word.
    f3 = w[14:12];
    case (r[3:0])
      4'd0:    w[6:0] = opc_lui;
      4'd1:    w[6:0] = opc_auipc;
      4'd2:    w[6:0] = opc_jal;
      4'd3:    w[6:0] = opc_jalr;
      4'd4:    w[6:0] = opc_branch;
      4'd5:    w[6:0] = opc_load;
      4'd6:    w[6:0] = opc_store;
      4'd7:    w[6:0] = opc_op_imm;
      4'd8:    w[6:0] = opc_op;
      4'd9:    w[6:0] = opc_fence;
      4'd10:   w[6:0] = opc_system;
      4'd11:   return NOP_INSTR;
      default: ; // Random and mostly unknown opcode.
    endcase
    if (r[6:4] != 3'd0) begin // Legal funct fields most of the time.
      case (w[6:0])
        opc_op: begin
          if (r[8:7] == 2'd1) w[31:25] = FUNCT7_ALT;
          else if (r[8:7] == 2'd2) w[31:25] = FUNCT7_MULDIV;
          else w[31:25] = FUNCT7_BASE;
        end
        opc_op_imm: begin
          if (f3 == 3'd1 || f3 == 3'd5)
            w[31:25] = (f3 == 3'd5 && r[9]) ? FUNCT7_ALT : FUNCT7_BASE;
        end
        opc_branch: if (f3[2:1] == 2'b01) w[14] = 1'b1;
        opc_load:   if (f3 == 3'd3 || f3 > 3'd5) w[14:12] = 3'd2;
        opc_store:  if (f3 > 3'd2) w[14:12] = {1'b0, r[8], ~r[8]};
        opc_system: begin
          if (f3 == 3'd0) begin
            case (r[8:7])
              2'd0:    w[31:20] = CSR_ECALL;
              2'd1:    w[31:20] = CSR_EBREAK;
              2'd2:    w[31:20] = CSR_MRET;
              default: w[31:20] = CSR_WFI;
            endcase
          end
        end
        default: ;
      endcase
    end else if (w[6:0] == opc_op) begin
      case (r[9:7]) // Removed bit-manipulation funct7 slots.
        3'd0:    w[31:25] = 7'h04;
        3'd1:    w[31:25] = 7'h05;
        3'd2:    w[31:25] = 7'h10;
        3'd3:    w[31:25] = 7'h14;
        3'd4:    w[31:25] = 7'h24;
        3'd5:    w[31:25] = 7'h30;
        3'd6:    w[31:25] = 7'h34;
        default: ; // Random funct7.
      endcase
    end
    case (r[11:10]) // Steer rd and rs1 to x0 and the link registers.
      2'd0:    w[11:7] = 5'd0;
      2'd1:    w[11:7] = r[12] ? LINK_REG_A : LINK_REG_B;
      default: ;
    endcase
    case (r[14:13])
      2'd0:    w[19:15] = 5'd0;
      2'd1:    w[19:15] = r[15] ? LINK_REG_A : LINK_REG_B;
      default: ;
    endcase
    return w;
  endfunction

  function automatic alu_op_e alu_for_funct3(input logic [2:0] f3);
    case (f3)
      3'd0:    return alu_add;
      3'd1:    return alu_sll;
      3'd2:    return alu_slt;
      3'd3:    return alu_sltu;
      3'd4:    return alu_xor;
      3'd5:    return alu_srl;
      3'd6:    return alu_or;
      default: return alu_and;
    endcase
  endfunction

  function automatic decode_out_t reference_decode(input logic [XLEN-1:0] w);
    decode_out_t e;
    logic [2:0]  f3;
    logic [6:0]  f7;
    logic [4:0]  rd;
    logic [4:0]  rs1;
    logic        rd_link;
    logic        rs1_link;
    logic        ok;
    e        = '0;
    ok       = 1'b1;
    f3       = w[14:12];
    f7       = w[31:25];
    rd       = w[11:7];
    rs1      = w[19:15];
    rd_link  = rd == LINK_REG_A || rd == LINK_REG_B;
    rs1_link = rs1 == LINK_REG_A || rs1 == LINK_REG_B;
    case (w[6:0])
      opc_lui, opc_auipc: begin
        e.lui   = w[6:0] == opc_lui;
        e.auipc = w[6:0] == opc_auipc;
        e.imm   = {w[31:12], 12'd0};
        e.wren  = rd != 5'd0;
      end
      opc_jal: begin
        e.jal  = 1'b1;
        e.imm  = {{12{w[31]}}, w[19:12], w[20], w[30:21], 1'b0};
        e.wren = rd != 5'd0;
        if (rd_link) e.return_push = 1'b1;
        else if (rd == 5'd0) e.jump_uncond = 1'b1;
        else e.jump_rest = 1'b1;
      end
      opc_jalr: begin
        e.jalr  = 1'b1;
        e.imm   = {{20{w[31]}}, w[31:20]};
        e.wren  = rd != 5'd0;
        e.rden1 = 1'b1;
        if (rd_link && rs1_link) begin
          e.return_push = 1'b1;
          e.return_pop  = rd != rs1;
        end else if (rd_link) begin
          e.return_push = 1'b1;
        end else if (rs1_link) begin
          e.return_pop = 1'b1;
        end else begin
          e.jump_rest = 1'b1;
        end
      end
      opc_branch: begin
        e.branch = 1'b1;
        e.imm    = {{20{w[31]}}, w[7], w[30:25], w[11:8], 1'b0};
        e.rden1  = 1'b1;
        e.rden2  = 1'b1;
        case (f3)
          3'd0:    e.bcu_op = bcu_beq;
          3'd1:    e.bcu_op = bcu_bne;
          3'd4:    e.bcu_op = bcu_blt;
          3'd5:    e.bcu_op = bcu_bge;
          3'd6:    e.bcu_op = bcu_bltu;
          3'd7:    e.bcu_op = bcu_bgeu;
          default: ok = 1'b0;
        endcase
      end
      opc_load: begin
        e.load  = 1'b1;
        e.imm   = {{20{w[31]}}, w[31:20]};
        e.wren  = rd != 5'd0;
        e.rden1 = 1'b1;
        case (f3)
          3'd0:    e.lsu_op = lsu_lb;
          3'd1:    e.lsu_op = lsu_lh;
          3'd2:    e.lsu_op = lsu_lw;
          3'd4:    e.lsu_op = lsu_lbu;
          3'd5:    e.lsu_op = lsu_lhu;
          default: ok = 1'b0;
        endcase
      end
      opc_store: begin
        e.store = 1'b1;
        e.imm   = {{20{w[31]}}, w[31:25], w[11:7]};
        e.rden1 = 1'b1;
        e.rden2 = 1'b1;
        case (f3)
          3'd0:    e.lsu_op = lsu_sb;
          3'd1:    e.lsu_op = lsu_sh;
          3'd2:    e.lsu_op = lsu_sw;
          default: ok = 1'b0;
        endcase
      end
      opc_op_imm: begin
        e.imm   = {{20{w[31]}}, w[31:20]};
        e.wren  = rd != 5'd0;
        e.rden1 = 1'b1;
        if (f3 == 3'd1) begin
          if (f7 == FUNCT7_BASE) e.alu_op = alu_sll;
          else ok = 1'b0;
        end else if (f3 == 3'd5) begin
          if (f7 == FUNCT7_BASE) e.alu_op = alu_srl;
          else if (f7 == FUNCT7_ALT) e.alu_op = alu_sra;
          else ok = 1'b0;
        end else begin
          e.alu_op = alu_for_funct3(f3);
        end
      end
      opc_op: begin
        e.wren  = rd != 5'd0;
        e.rden1 = 1'b1;
        e.rden2 = 1'b1;
        if (f7 == FUNCT7_BASE) begin
          e.alu_op = alu_for_funct3(f3);
        end else if (f7 == FUNCT7_ALT) begin
          if (f3 == 3'd0) e.alu_op = alu_sub;
          else if (f3 == 3'd5) e.alu_op = alu_sra;
          else ok = 1'b0;
        end else if (f7 == FUNCT7_MULDIV) begin
          e.mult     = !f3[2];
          e.division = f3[2];
          case (f3)
            3'd0:    e.muldiv_op = md_mul;
            3'd1:    e.muldiv_op = md_mulh;
            3'd2:    e.muldiv_op = md_mulhsu;
            3'd3:    e.muldiv_op = md_mulhu;
            3'd4:    e.muldiv_op = md_div;
            3'd5:    e.muldiv_op = md_divu;
            3'd6:    e.muldiv_op = md_rem;
            default: e.muldiv_op = md_remu;
          endcase
        end else if (f7 inside {7'h04, 7'h05, 7'h10, 7'h14, 7'h24, 7'h30, 7'h34}) begin
          ok = 1'b0; // Bit-manipulation encodings.
        end
      end
      opc_fence: e.fence = f3 <= 3'd1;
      opc_system: begin
        e.imm = {27'd0, rs1};
        if (f3 == 3'd0) begin
          case (w[31:20])
            CSR_ECALL:  e.ecall = 1'b1;
            CSR_EBREAK: e.ebreak = 1'b1;
            CSR_MRET:   e.mret = 1'b1;
            CSR_WFI:    e.wfi = 1'b1;
            default:    ok = 1'b0;
          endcase
        end else if (f3 != 3'd4) begin
          e.csreg = 1'b1;
          e.wren  = rd != 5'd0;
          e.rden1 = !f3[2];
          case (f3)
            3'd1:    e.csr_op = csr_rw;
            3'd2:    e.csr_op = csr_rs;
            3'd3:    e.csr_op = csr_rc;
            3'd5:    e.csr_op = csr_rwi;
            3'd6:    e.csr_op = csr_rsi;
            default: e.csr_op = csr_rci;
          endcase
          if (f3[1:0] == 2'b01) begin
            e.cwren = 1'b1;
            e.crden = rd != 5'd0;
          end else begin
            e.cwren = rs1 != 5'd0;
            e.crden = 1'b1;
          end
        end
      end
      default: ok = 1'b0;
    endcase
    if (w == NOP_INSTR) begin
      e.nop    = 1'b1;
      e.alu_op = alu_none;
    end
    e.legal = ok;
    return e;
  endfunction

  task automatic compare_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
    if (got !== exp) begin
      $display("CHECK FAILED %s got 0x%08h expected 0x%08h (instr 0x%08h)",
               name, got, exp, last_instr);
      $display("Test failures found");
      $fatal(1, "Mismatch on %s.", name);
    end
  endtask

  task automatic compare_outputs(input decode_out_t exp);
    compare_value("decode_out.imm", decode_out.imm, exp.imm);
    compare_value("decode_out.wren", 32'(decode_out.wren), 32'(exp.wren));
    compare_value("decode_out.rden1", 32'(decode_out.rden1), 32'(exp.rden1));
    compare_value("decode_out.rden2", 32'(decode_out.rden2), 32'(exp.rden2));
    compare_value("decode_out.cwren", 32'(decode_out.cwren), 32'(exp.cwren));
    compare_value("decode_out.crden", 32'(decode_out.crden), 32'(exp.crden));
    compare_value("decode_out.lui", 32'(decode_out.lui), 32'(exp.lui));
    compare_value("decode_out.auipc", 32'(decode_out.auipc), 32'(exp.auipc));
    compare_value("decode_out.jal", 32'(decode_out.jal), 32'(exp.jal));
    compare_value("decode_out.jalr", 32'(decode_out.jalr), 32'(exp.jalr));
    compare_value("decode_out.branch", 32'(decode_out.branch), 32'(exp.branch));
    compare_value("decode_out.load", 32'(decode_out.load), 32'(exp.load));
    compare_value("decode_out.store", 32'(decode_out.store), 32'(exp.store));
    compare_value("decode_out.nop", 32'(decode_out.nop), 32'(exp.nop));
    compare_value("decode_out.csreg", 32'(decode_out.csreg), 32'(exp.csreg));
    compare_value("decode_out.mult", 32'(decode_out.mult), 32'(exp.mult));
    compare_value("decode_out.division", 32'(decode_out.division), 32'(exp.division));
    compare_value("decode_out.fence", 32'(decode_out.fence), 32'(exp.fence));
    compare_value("decode_out.ecall", 32'(decode_out.ecall), 32'(exp.ecall));
    compare_value("decode_out.ebreak", 32'(decode_out.ebreak), 32'(exp.ebreak));
    compare_value("decode_out.mret", 32'(decode_out.mret), 32'(exp.mret));
    compare_value("decode_out.wfi", 32'(decode_out.wfi), 32'(exp.wfi));
    compare_value("decode_out.return_push", 32'(decode_out.return_push),
                  32'(exp.return_push));
    compare_value("decode_out.return_pop", 32'(decode_out.return_pop),
                  32'(exp.return_pop));
    compare_value("decode_out.jump_uncond", 32'(decode_out.jump_uncond),
                  32'(exp.jump_uncond));
    compare_value("decode_out.jump_rest", 32'(decode_out.jump_rest), 32'(exp.jump_rest));
    compare_value("decode_out.legal", 32'(decode_out.legal), 32'(exp.legal));
    compare_value("decode_out.alu_op", 32'(decode_out.alu_op), 32'(exp.alu_op));
    compare_value("decode_out.muldiv_op", 32'(decode_out.muldiv_op), 32'(exp.muldiv_op));
    compare_value("decode_out.bcu_op", 32'(decode_out.bcu_op), 32'(exp.bcu_op));
    compare_value("decode_out.lsu_op", 32'(decode_out.lsu_op), 32'(exp.lsu_op));
    compare_value("decode_out.csr_op", 32'(decode_out.csr_op), 32'(exp.csr_op));
  endtask

  // Outputs seen at a falling edge come from the word driven one cycle earlier.
  task automatic check_cycle();
    compare_value("out_valid", 32'(out_valid), 32'(last_valid));
    if (last_valid) expected = reference_decode(last_instr);
    compare_outputs(expected); // Holds its old value without a strobe.
  endtask

  initial begin
    lcg_state  = 32'h815a_8d05;
    rst        = 1'b1;
    in_valid   = 1'b1; // Ignored under reset.
    instr      = random_instr();
    last_instr = '0;
    last_valid = 1'b0;
    expected   = '0;
    strobes    = 0;
    repeat (10) @(negedge clock);
    rst = 1'b0;
    while (strobes < NUM_STROBES) begin
      check_cycle();
      in_valid   = lcg_next() >= 32'h4000_0000; // Three in four.
      instr      = random_instr();
      last_valid = in_valid;
      last_instr = instr;
      if (in_valid) strobes++;
      @(negedge clock);
    end
    check_cycle();
    $display("All tests passed!");
    $finish;
  end

endmodule

// File: flist.f
hw/rv_decode_pkg.sv
hw/imm_gen.sv
hw/alu_decode.sv
hw/csr_decode.sv
hw/ras_hint.sv
hw/decode_ctrl.sv
hw/decode_stage.sv
bench/decode_stage_props.sv
bench/tb_decode_stage.sv

// File: run.sh
#!/bin/sh
# Build and run the decode stage testbench with Verilator.
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -j 0 \
  --top-module tb_decode_stage -f flist.f -o sim_decode_stage
./obj_dir/sim_decode_stage
